// ==== source/divsqrt_cfg_pkg.sv ====
// ----------------------------------------------------------------------
// divide/sqrt unit configuration
// datapath, tag and counter widths with their vector types
// ----------------------------------------------------------------------
`default_nettype none

package divsqrt_cfg_pkg;

  localparam int unsigned DATA_W   = 32;  // operand and result width
  localparam int unsigned TAG_W    = 4;   // transaction tag
  localparam int unsigned CNT_W    = 6;   // iteration counter, holds up to 32
  localparam int unsigned STATUS_W = 2;   // dz and nx flags
  localparam int unsigned OP_W     = 1;   // encoding width of the operation
  localparam int unsigned FMT_W    = 2;   // encoding width of the format

  // stage payloads, fields packed msb first in the order listed
  localparam int unsigned IN_PAYLOAD_W  = 2*DATA_W + OP_W + FMT_W + TAG_W; // opa opb op fmt tag
  localparam int unsigned OUT_PAYLOAD_W = DATA_W + STATUS_W + TAG_W;       // result status tag

  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [CNT_W-1:0]    cnt_t;
  typedef logic [STATUS_W-1:0] status_t;

endpackage

`default_nettype wire

// ==== source/divsqrt_op_pkg.sv ====
// ----------------------------------------------------------------------
// divide/sqrt unit encodings
// operation, format, control FSM states and status bit positions
// ----------------------------------------------------------------------
`default_nettype none

package divsqrt_op_pkg;

  import divsqrt_cfg_pkg::*;

  typedef enum logic [OP_W-1:0] {
    OP_DIV  = 1'b0,  // unsigned a/b, truncated
    OP_SQRT = 1'b1   // floor(sqrt(a)), b unused
  } op_e;

  // active width N of the operands
  typedef enum logic [FMT_W-1:0] {
    FMT_W32 = 2'd0,
    FMT_W16 = 2'd1,
    FMT_W8  = 2'd2   // 2'd3 is not used, treated as 32 bit
  } fmt_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0,  // waiting for work
    BUSY = 2'd1,  // core iterating
    HOLD = 2'd2   // result waits for the output stage
  } ctrl_state_e;

  // bit positions in status_t
  localparam int unsigned ST_DZ = 1;  // divide by zero
  localparam int unsigned ST_NX = 0;  // inexact, remainder left over

endpackage

`default_nettype wire

// ==== source/divsqrt_pipe_stage.sv ====
// ----------------------------------------------------------------------
// valid/ready register stage
// one cycle of latency, ready pops bubbles so an empty stage always loads
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_pipe_stage #(
  parameter int unsigned PAYLOAD_W = 8  // width of the carried payload
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // upstream side
  input  logic                 valid_i,
  output logic                 ready_o,
  input  logic [PAYLOAD_W-1:0] data_i,
  // downstream side
  output logic                 valid_o,
  input  logic                 ready_i,
  output logic [PAYLOAD_W-1:0] data_o
);

  logic                 valid_q;
  logic [PAYLOAD_W-1:0] data_q;

  // advance when downstream takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;

  // valid register, enabled by ready
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // payload only loads on a real transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// ==== source/divsqrt_ctrl.sv ====
// ----------------------------------------------------------------------
// divide/sqrt issue and complete control
// IDLE/BUSY/HOLD FSM between input stage, core and output stage
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_ctrl
  import divsqrt_cfg_pkg::*;
  import divsqrt_op_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  // from the input stage
  input  logic in_valid_i,
  output logic in_ready_o,
  input  tag_t tag_i,
  // core handshake
  output logic start_o,     // one cycle, core latches operands on this edge
  input  logic done_i,      // one cycle, core result valid from here on
  // to the output stage
  output logic out_valid_o,
  input  logic out_ready_i,
  output tag_t tag_o,
  output logic busy_o       // operation in flight
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        in_ready;    // FSM accepts a new item
  logic        out_valid;   // result offered downstream
  tag_t        tag_q;       // tag of the operation in the core

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------
  always_comb begin : fsm_next
    in_ready  = 1'b0;
    out_valid = 1'b0;
    state_d   = state_q;

    unique case (state_q)
      IDLE: begin
        in_ready = 1'b1;                 // core is free
        if (in_valid_i) state_d = BUSY;  // start right away
      end
      BUSY: begin
        if (done_i) begin
          out_valid = 1'b1;              // offer result in the done cycle
          if (out_ready_i) begin
            in_ready = 1'b1;             // core frees up on this edge
            state_d  = in_valid_i ? BUSY : IDLE;
          end else begin
            state_d = HOLD;              // core keeps the result stable meanwhile
          end
        end
      end
      HOLD: begin
        out_valid = 1'b1;
        if (out_ready_i) begin
          in_ready = 1'b1;
          state_d  = in_valid_i ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // tag follows the operation into the core, output stage grabs the old one on the same edge
  always_ff @(posedge clk_i) begin
    if (start_o) begin
      tag_q <= tag_i;
    end
  end

  assign start_o     = in_valid_i & in_ready;
  assign in_ready_o  = in_ready;
  assign out_valid_o = out_valid;
  assign tag_o       = tag_q;
  assign busy_o      = (state_q == BUSY) || (state_q == HOLD);

endmodule

`default_nettype wire

// ==== source/divsqrt_iter_core.sv ====
// ----------------------------------------------------------------------
// iterative divide/sqrt core
// restoring divide at 1 bit/cycle and digit sqrt at 2 bits/cycle over 8/16/32 bit
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_iter_core
  import divsqrt_cfg_pkg::*;
  import divsqrt_op_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    start_i,    // latch operands and run the first step
  input  op_e     op_i,
  input  fmt_e    fmt_i,
  input  data_t   opa_i,
  input  data_t   opb_i,
  output logic    done_o,     // N (div) or N/2 (sqrt) cycles after start
  output data_t   result_o,   // stable from done until the next start
  output status_t status_o
);

  localparam int unsigned ROOT_W = DATA_W/2;

  // active width N of a format
  function automatic cnt_t fmt_bits(input fmt_e fmt);
    cnt_t n;
    case (fmt)
      FMT_W16: n = cnt_t'(16);
      FMT_W8:  n = cnt_t'(8);
      default: n = cnt_t'(DATA_W);
    endcase
    return n;
  endfunction

  // ones in the low N bits
  function automatic data_t fmt_mask(input fmt_e fmt);
    data_t ones;
    ones = '1;
    return ones >> (DATA_W - 32'(fmt_bits(fmt)));
  endfunction

  // ----------------------------------------------------------------------
  // state
  // ----------------------------------------------------------------------
  op_e               op_q;
  fmt_e              fmt_q;
  data_t             divisor_q;   // masked b
  data_t             shift_q;     // left aligned a with quotient bits entering at the lsb
  data_t             rem_q;       // partial remainder
  logic [ROOT_W-1:0] root_q;      // partial root
  cnt_t              cnt_q;       // steps still to go after this one
  logic              busy_q;
  logic              done_q;

  // step inputs come straight from the ports in the start cycle
  op_e               cur_op;
  data_t             cur_div;
  data_t             cur_shift;
  data_t             cur_rem;
  logic [ROOT_W-1:0] cur_root;
  cnt_t              cnt_load;    // steps after the first one

  always_comb begin : step_src
    if (start_i) begin
      cur_op    = op_i;
      cur_div   = opb_i & fmt_mask(fmt_i);
      // msb of N at the top
      cur_shift = (opa_i & fmt_mask(fmt_i)) << (DATA_W - 32'(fmt_bits(fmt_i)));
      cur_rem   = '0;
      cur_root  = '0;
    end else begin
      cur_op    = op_q;
      cur_div   = divisor_q;
      cur_shift = shift_q;
      cur_rem   = rem_q;
      cur_root  = root_q;
    end
  end

  assign cnt_load = (op_i == OP_DIV) ? fmt_bits(fmt_i) - cnt_t'(1)
                                     : (fmt_bits(fmt_i) >> 1) - cnt_t'(1);

  // ----------------------------------------------------------------------
  // one recurrence step
  // ----------------------------------------------------------------------
  logic [DATA_W+1:0] div_trial;   // msb set means borrow so the old remainder stays
  logic              div_neg;
  data_t             sq_part;     // remainder with the next two radicand bits
  logic [DATA_W:0]   sq_trial;    // part minus 4*root+1
  logic              sq_neg;
  data_t             rem_d;
  data_t             shift_d;
  logic [ROOT_W-1:0] root_d;

  assign div_trial = {1'b0, cur_rem, cur_shift[DATA_W-1]} - {2'b00, cur_div};
  assign div_neg   = div_trial[DATA_W+1];

  // remainder stays below 2^(ROOT_W+1) so its top two bits are zero
  assign sq_part  = {cur_rem[DATA_W-3:0], cur_shift[DATA_W-1 -: 2]};
  assign sq_trial = {1'b0, sq_part} - {{(ROOT_W-1){1'b0}}, cur_root, 2'b01};
  assign sq_neg   = sq_trial[DATA_W];

  always_comb begin : step_next
    if (cur_op == OP_DIV) begin
      rem_d   = div_neg ? {cur_rem[DATA_W-2:0], cur_shift[DATA_W-1]} : div_trial[DATA_W-1:0];
      shift_d = {cur_shift[DATA_W-2:0], ~div_neg};  // quotient bit in
      root_d  = cur_root;
    end else begin
      rem_d   = sq_neg ? sq_part : sq_trial[DATA_W-1:0];
      shift_d = {cur_shift[DATA_W-3:0], 2'b00};     // two radicand bits consumed
      root_d  = {cur_root[ROOT_W-2:0], ~sq_neg};    // root digit in
    end
  end

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= cnt_load;
      end else if (busy_q) begin
        cnt_q <= cnt_q - cnt_t'(1);
        if (cnt_q == cnt_t'(1)) begin  // last step on this edge
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q      <= op_i;
      fmt_q     <= fmt_i;
      divisor_q <= cur_div;
    end
    if (start_i || busy_q) begin  // frozen once done so the result holds
      shift_q <= shift_d;
      rem_q   <= rem_d;
      root_q  <= root_d;
    end
  end

  // ----------------------------------------------------------------------
  // result boxing and flags
  // ----------------------------------------------------------------------
  data_t act_mask;
  logic  div_zero;

  assign act_mask = fmt_mask(fmt_q);
  assign div_zero = (divisor_q == '0);  // every trial passes so the quotient is all ones

  always_comb begin : result_form
    status_o = '0;
    if (op_q == OP_DIV) begin
      result_o        = shift_q | ~act_mask;
      status_o[ST_DZ] = div_zero;
      status_o[ST_NX] = ~div_zero & (rem_q != '0);  // no inexact on top of dz
    end else begin
      result_o        = data_t'(root_q) | ~act_mask;
      status_o[ST_NX] = (rem_q != '0);              // not a perfect square
    end
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

// ==== source/divsqrt_top.sv ====
// ----------------------------------------------------------------------
// divide/sqrt unit top
// input stage, control FSM, iterative core and output stage
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_top
  import divsqrt_cfg_pkg::*;
  import divsqrt_op_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  // input handshake
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  data_t   opa_i,
  input  data_t   opb_i,
  input  op_e     op_i,
  input  fmt_e    fmt_i,
  input  tag_t    tag_i,
  // output handshake
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output data_t   result_o,
  output status_t status_o,
  output tag_t    tag_o,
  output logic    busy_o       // anything in flight
);

  // input stage to FSM and core
  logic                     in_q_valid;
  logic                     in_q_ready;
  logic [IN_PAYLOAD_W-1:0]  in_d_data;
  logic [IN_PAYLOAD_W-1:0]  in_q_data;
  data_t                    in_q_opa;
  data_t                    in_q_opb;
  logic [OP_W-1:0]          in_q_op;
  logic [FMT_W-1:0]         in_q_fmt;
  tag_t                     in_q_tag;
  // FSM and core
  logic                     core_start;
  logic                     core_done;
  data_t                    core_result;
  status_t                  core_status;
  tag_t                     held_tag;
  logic                     ctrl_busy;
  // FSM to output stage
  logic                     out_pre_valid;
  logic                     out_pre_ready;
  logic [OUT_PAYLOAD_W-1:0] out_d_data;
  logic [OUT_PAYLOAD_W-1:0] out_q_data;

  // ----------------------------------------------------------------------
  // input pipeline
  // ----------------------------------------------------------------------
  assign in_d_data = {opa_i, opb_i, op_i, fmt_i, tag_i};

  divsqrt_pipe_stage #(.PAYLOAD_W(IN_PAYLOAD_W)) u_in_stage (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (in_d_data),
    .valid_o (in_q_valid),
    .ready_i (in_q_ready),
    .data_o  (in_q_data)
  );

  assign {in_q_opa, in_q_opb, in_q_op, in_q_fmt, in_q_tag} = in_q_data;

  // ----------------------------------------------------------------------
  // control and core
  // ----------------------------------------------------------------------
  divsqrt_ctrl u_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_q_valid),
    .in_ready_o  (in_q_ready),
    .tag_i       (in_q_tag),
    .start_o     (core_start),
    .done_i      (core_done),
    .out_valid_o (out_pre_valid),
    .out_ready_i (out_pre_ready),
    .tag_o       (held_tag),
    .busy_o      (ctrl_busy)
  );

  divsqrt_iter_core u_core (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (core_start),
    .op_i     (op_e'(in_q_op)),
    .fmt_i    (fmt_e'(in_q_fmt)),
    .opa_i    (in_q_opa),
    .opb_i    (in_q_opb),
    .done_o   (core_done),
    .result_o (core_result),
    .status_o (core_status)
  );

  // ----------------------------------------------------------------------
  // output pipeline
  // ----------------------------------------------------------------------
  assign out_d_data = {core_result, core_status, held_tag};

  divsqrt_pipe_stage #(.PAYLOAD_W(OUT_PAYLOAD_W)) u_out_stage (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (out_pre_valid),
    .ready_o (out_pre_ready),
    .data_i  (out_d_data),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_q_data)
  );

  assign {result_o, status_o, tag_o} = out_q_data;

  assign busy_o = in_q_valid | ctrl_busy | out_valid_o;  // either stage or the core holds work

endmodule

`default_nettype wire

// ==== verification/divsqrt_tb.sv ====
// ----------------------------------------------------------------------
// divide/sqrt unit testbench
// directed table and a random back-to-back stream checked through a queue
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_tb
  import divsqrt_cfg_pkg::*;
  import divsqrt_op_pkg::*;
();

  localparam int NUM_DIRECTED = 15;
  localparam int NUM_RANDOM   = 300;
  localparam int TIMEOUT      = 200;   // cycles per handshake wait
  localparam int DRAIN_LIMIT  = 2000;  // cycles to empty the unit at the end

  typedef struct packed {
    op_e     op;
    fmt_e    fmt;
    data_t   a;
    data_t   b;
    data_t   res;     // expected result with ones above N
    status_t st;      // {dz, nx}
  } vec_t;

  typedef struct packed {
    data_t   result;
    status_t status;
    tag_t    tag;
  } exp_t;

  // hand computed cases with junk in the upper operand bits
  localparam vec_t DIRECTED [NUM_DIRECTED] = '{
    '{OP_DIV,  FMT_W32, 32'd100,      32'd7,        32'h0000_000E, 2'b01},
    '{OP_DIV,  FMT_W32, 32'hFFFF_FFFF, 32'd1,       32'hFFFF_FFFF, 2'b00},
    '{OP_DIV,  FMT_W32, 32'd5,        32'd0,        32'hFFFF_FFFF, 2'b10},
    '{OP_DIV,  FMT_W16, 32'hABCD_1000, 32'h1234_0010, 32'hFFFF_0100, 2'b00},
    '{OP_DIV,  FMT_W16, 32'h0000_FFFF, 32'hFFFF_0000, 32'hFFFF_FFFF, 2'b10},
    '{OP_DIV,  FMT_W8,  32'h1234_56C8, 32'h0000_0A0A, 32'hFFFF_FF14, 2'b00},
    '{OP_DIV,  FMT_W8,  32'h0000_00FF, 32'h0000_0004, 32'hFFFF_FF3F, 2'b01},
    '{OP_DIV,  FMT_W8,  32'h0000_0010, 32'h0000_0100, 32'hFFFF_FFFF, 2'b10},
    '{OP_SQRT, FMT_W32, 32'hFFFF_FFFF, 32'h5555_5555, 32'h0000_FFFF, 2'b01},
    '{OP_SQRT, FMT_W32, 32'd144,      32'd0,        32'h0000_000C, 2'b00},
    '{OP_SQRT, FMT_W16, 32'hDEAD_0051, 32'h0000_0000, 32'hFFFF_0009, 2'b00},
    '{OP_SQRT, FMT_W16, 32'h0000_FFFF, 32'h0000_0000, 32'hFFFF_00FF, 2'b01},
    '{OP_SQRT, FMT_W8,  32'h1234_5664, 32'h0000_0000, 32'hFFFF_FF0A, 2'b00},
    '{OP_SQRT, FMT_W8,  32'h0000_00C8, 32'h0000_0000, 32'hFFFF_FF0E, 2'b01},
    '{OP_SQRT, FMT_W8,  32'h0000_0000, 32'h0000_0000, 32'hFFFF_FF00, 2'b00}
  };

  logic    clk_i;
  logic    reset_i;
  logic    in_valid_i;
  logic    in_ready_o;
  data_t   opa_i;
  data_t   opb_i;
  op_e     op_i;
  fmt_e    fmt_i;
  tag_t    tag_i;
  logic    out_valid_o;
  logic    out_ready_i;
  data_t   result_o;
  status_t status_o;
  tag_t    tag_o;
  logic    busy_o;

  integer  seed = 23173;
  exp_t    exp_q[$];       // results in order of acceptance
  tag_t    tag_cnt = '0;

  divsqrt_top uut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .opa_i       (opa_i),
    .opb_i       (opb_i),
    .op_i        (op_i),
    .fmt_i       (fmt_i),
    .tag_i       (tag_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;  // 10 ns period
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // reference model of the arithmetic rules
  task automatic compute_expected(input op_e op, input fmt_e fmt, input data_t a,
                                  input data_t b, output data_t res, output status_t st);
    data_t           mask;
    data_t           am;
    data_t           bm;
    longint unsigned r;
    longint unsigned t;
    mask = (fmt == FMT_W16) ? 32'h0000_FFFF : (fmt == FMT_W8) ? 32'h0000_00FF : '1;
    am   = a & mask;
    bm   = b & mask;
    st   = '0;
    if (op == OP_DIV) begin
      if (bm == '0) begin
        res        = mask;  // all ones in N bits
        st[ST_DZ]  = 1'b1;
      end else begin
        res        = am / bm;
        st[ST_NX]  = (am % bm) != '0;
      end
    end else begin
      r = 0;
      for (int k = 15; k >= 0; k--) begin  // build the root bit by bit
        t = r | (64'd1 << k);
        if (t * t <= 64'(am)) r = t;
      end
      res       = data_t'(r);
      st[ST_NX] = (r * r) != 64'(am);
    end
    res = res | ~mask;  // boxing
  endtask

  // offer one item and hold valid until the DUT takes it
  task automatic send_item(input op_e op, input fmt_e fmt, input data_t a, input data_t b,
                           input data_t res, input status_t st);
    int   waited;
    exp_t item;
    item.result = res;
    item.status = st;
    item.tag    = tag_cnt;
    exp_q.push_back(item);
    in_valid_i = 1'b1;
    op_i       = op;
    fmt_i      = fmt;
    opa_i      = a;
    opb_i      = b;
    tag_i      = tag_cnt;
    waited     = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) abort_run("in_ready_o stayed low, input was never accepted");
    end while (!in_ready_o);
    @(posedge clk_i);  // transfer edge
    #1;
    tag_cnt = tag_cnt + tag_t'(1);
  endtask

  // ----------------------------------------------------------------------
  // output side with random back-pressure and the scoreboard
  // ----------------------------------------------------------------------
  initial begin
    logic ready_next;
    out_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      ready_next = ($random(seed) % 4) == 0;  // ready about 1 cycle in 4
      @(posedge clk_i);
      #1;
      out_ready_i = ready_next;
    end
  end

  initial begin
    exp_t exp;
    forever begin
      @(negedge clk_i);
      if (!reset_i && out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) abort_run("a result came out with no operation pending");
        exp = exp_q.pop_front();
        check_value("tag_o", 32'(tag_o), 32'(exp.tag));  // issue order
        check_value("result_o", result_o, exp.result);
        check_value("status_o", 32'(status_o), 32'(exp.status));
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    data_t   a;
    data_t   b;
    data_t   res;
    status_t st;
    op_e     op;
    fmt_e    fmt;
    int      sel;
    int      waited;
    reset_i    = 1'b1;
    in_valid_i = 1'b0;
    opa_i      = '0;
    opb_i      = '0;
    op_i       = OP_DIV;
    fmt_i      = FMT_W32;
    tag_i      = '0;
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    @(negedge clk_i);
    check_value("out_valid_o after reset", 32'(out_valid_o), 32'd0);
    check_value("busy_o after reset", 32'(busy_o), 32'd0);
    check_value("in_ready_o after reset", 32'(in_ready_o), 32'd1);
    @(posedge clk_i);
    #1;

    for (int i = 0; i < NUM_DIRECTED; i++) begin
      send_item(DIRECTED[i].op, DIRECTED[i].fmt, DIRECTED[i].a, DIRECTED[i].b,
                DIRECTED[i].res, DIRECTED[i].st);
    end

    // mixed stream with valid held high between items
    for (int i = 0; i < NUM_RANDOM; i++) begin
      sel = $random(seed);
      a   = $random(seed);
      b   = $random(seed);
      op  = sel[0] ? OP_SQRT : OP_DIV;
      fmt = (sel[2:1] == 2'd1) ? FMT_W16 : (sel[2:1] == 2'd2) ? FMT_W8 : FMT_W32;
      if (sel[5:3] == 3'd0) b = '0;                      // divide by zero
      else if (sel[5:3] < 3'd3) b = b & 32'h0000_00FF;   // small divisor for a big quotient
      if (op == OP_SQRT && sel[7:6] == 2'd0) a = 32'(a[7:0]) * 32'(a[7:0]);
      compute_expected(op, fmt, a, b, res, st);
      send_item(op, fmt, a, b, res, st);
    end
    in_valid_i = 1'b0;

    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > DRAIN_LIMIT) abort_run("results still missing after the last input");
    end
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) abort_run("busy_o did not return low after the unit drained");
    end while (busy_o);

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/divsqrt_cfg_pkg.sv
source/divsqrt_op_pkg.sv
source/divsqrt_pipe_stage.sv
source/divsqrt_ctrl.sv
source/divsqrt_iter_core.sv
source/divsqrt_top.sv
verification/divsqrt_tb.sv

// ==== Makefile ====
# Verilator build and run of the divide/sqrt unit testbench

SRCS := $(wildcard source/*.sv) verification/divsqrt_tb.sv

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vdivsqrt_tb: list.f $(SRCS)
	verilator --binary -j 0 --top-module divsqrt_tb -f list.f -o Vdivsqrt_tb

run: obj_dir/Vdivsqrt_tb
	-./obj_dir/Vdivsqrt_tb > sim.log 2>&1
	cat sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
